// File: compile.f
+incdir+sim
hw/cordicPkg.sv
hw/angleDecoder.sv
hw/cordicRotator.sv
hw/resultEncoder.sv
hw/cosineUnit.sv
sim/cosineUnitTb.sv

// File: hw/angleDecoder.sv
`timescale 1ns/1ps

module angleDecoder (
    input  cordicPkg::floatWord_t angle,
    output cordicPkg::fixed_t     fixedAngle
);
    import cordicPkg::*;

    logic [7:0]            exponent;
    logic [7:0]            shiftDistance;
    logic [fixedWidth-1:0] hiddenMantissa;

    assign exponent = angle.fields.exponent;

    // 1.f with the leading one at the Q1.20 integer position
    // the low mantissa bits would be shifted out anyway
    assign hiddenMantissa = {1'b1, angle.fields.mantissa[22 -: fracBits]};

    // only meaningful while exponent is below the bias
    assign shiftDistance = 8'(floatBias) - exponent;

    // sign field is never read, cosine is even
    always_comb begin
        if (exponent >= 8'(floatBias)) begin
            // one radian or more, clamp just below 1.0
            fixedAngle = {1'b0, {fracBits{1'b1}}};
        end else if (shiftDistance > 8'(fracBits)) begin
            // below the smallest fraction bit
            fixedAngle = '0;
        end else begin
            fixedAngle = fixed_t'(hiddenMantissa >> shiftDistance);
        end
    end

endmodule

// File: hw/cordicPkg.sv
package cordicPkg;

    // ------------------------------------------------------------------------
    // fixed-point datapath
    // ------------------------------------------------------------------------

    // one sign bit plus twenty fraction bits
    localparam int fixedWidth = 21;
    localparam int fracBits   = 20;

    localparam int iterations = 16;
    // wide enough to hold the value sixteen itself
    localparam int indexWidth = 5;

    typedef logic signed [fixedWidth-1:0] fixed_t;

    // 1/K for sixteen iterations, about 0.60725
    localparam fixed_t cordicGain = 21'h09B74E;

    // ------------------------------------------------------------------------
    // single-precision float
    // ------------------------------------------------------------------------

    localparam int floatBias = 127;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } floatFields_t;

    // raw bits at the ports, fields inside decoder and encoder
    typedef union packed {
        logic [31:0]  raw;
        floatFields_t fields;
    } floatWord_t;

    // ------------------------------------------------------------------------
    // arctangent table
    // ------------------------------------------------------------------------

    // atan(2^-i) in Q1.20, rounded
    localparam fixed_t atanTable [iterations] = '{
        21'h0C90FE,
        21'h076B1A,
        21'h03EB6F,
        21'h01FD5C,
        21'h00FFAB,
        21'h007FF5,
        21'h003FFF,
        21'h002000,
        // from here on atan(x) is x to table precision
        21'h001000,
        21'h000800,
        21'h000400,
        21'h000200,
        21'h000100,
        21'h000080,
        21'h000040,
        21'h000020
    };

endpackage

// File: hw/cordicRotator.sv
`timescale 1ns/1ps

module cordicRotator (
    input  logic              clock,
    input  logic              reset,
    input  logic              clockEnable,
    input  logic              start,
    input  cordicPkg::fixed_t fixedAngle,
    output cordicPkg::fixed_t cosineFixed,
    output logic              done
);
    import cordicPkg::*;

    fixed_t                x;
    fixed_t                y;
    fixed_t                z;
    logic [indexWidth-1:0] counter;

    fixed_t xShifted;
    fixed_t yShifted;
    fixed_t stepAngle;
    fixed_t xNext;
    fixed_t yNext;
    fixed_t zNext;

    // ------------------------------------------------------------------------
    // one rotation step
    // ------------------------------------------------------------------------

    assign xShifted = x >>> counter;
    assign yShifted = y >>> counter;

    // counter only reaches 16 once iterating has stopped
    assign stepAngle = atanTable[counter[indexWidth-2:0]];

    // drive z toward zero, direction from its sign
    always_comb begin
        if (!z[fixedWidth-1]) begin
            xNext = x - yShifted;
            yNext = y + xShifted;
            zNext = z - stepAngle;
        end else begin
            xNext = x + yShifted;
            yNext = y - xShifted;
            zNext = z + stepAngle;
        end
    end

    // ------------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------------

    assign done = (counter == indexWidth'(iterations));

    always_ff @(posedge clock) begin
        if (reset) begin
            counter <= '0;
            x       <= cordicGain;
            y       <= '0;
            z       <= '0;
        end else if (clockEnable) begin
            if (start) begin
                // restart, any running computation is dropped
                counter <= '0;
                x       <= cordicGain;
                y       <= '0;
                z       <= fixedAngle;
            end else if (!done) begin
                counter <= counter + 1'b1;
                x       <= xNext;
                y       <= yNext;
                z       <= zNext;
            end
        end
    end

    assign cosineFixed = x;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    counterInRange: assert property (
        @(posedge clock) disable iff (reset)
        counter <= indexWidth'(iterations)
    ) else $error("cordicRotator: counter %0d past limit", counter);

    doneHeld: assert property (
        @(posedge clock) disable iff (reset)
        done && !(clockEnable && start) |=> done
    ) else $error("cordicRotator: done dropped without a start");

    // stalled cycles must not touch the datapath
    stallHolds: assert property (
        @(posedge clock) disable iff (reset)
        !clockEnable |=> $stable(x) && $stable(y) && $stable(z) && $stable(counter)
    ) else $error("cordicRotator: state changed with clockEnable low");

endmodule

// File: hw/cosineUnit.sv
`timescale 1ns/1ps

module cosineUnit (
    input  logic        clock,
    input  logic        reset,
    input  logic        clockEnable,
    input  logic        start,
    input  logic [31:0] angle,
    output logic [31:0] result,
    output logic        done
);
    import cordicPkg::*;

    floatWord_t angleWord;
    floatWord_t resultWord;
    fixed_t     fixedAngle;
    fixed_t     cosineFixed;

    assign angleWord.raw = angle;

    // float angle to non-negative Q1.20
    angleDecoder decoder (
        .angle      (angleWord),
        .fixedAngle (fixedAngle)
    );

    // sixteen enabled cycles from start to done
    cordicRotator rotator (
        .clock       (clock),
        .reset       (reset),
        .clockEnable (clockEnable),
        .start       (start),
        .fixedAngle  (fixedAngle),
        .cosineFixed (cosineFixed),
        .done        (done)
    );

    // combinational, result follows x directly
    resultEncoder encoder (
        .cosineFixed (cosineFixed),
        .result      (resultWord)
    );

    assign result = resultWord.raw;

endmodule

// File: hw/resultEncoder.sv
`timescale 1ns/1ps

module resultEncoder (
    input  cordicPkg::fixed_t     cosineFixed,
    output cordicPkg::floatWord_t result
);
    import cordicPkg::*;

    logic                          isNegative;
    logic [fixedWidth-1:0]         magnitude;
    logic [$clog2(fixedWidth)-1:0] leadPos;
    logic [fixedWidth-1:0]         normalized;

    // negative x only appears from rounding near pi/2
    assign isNegative = cosineFixed[fixedWidth-1];

    // -1.0 negates to itself, read unsigned it is still right
    assign magnitude = isNegative ? fixedWidth'(-cosineFixed)
                                  : fixedWidth'(cosineFixed);

    // leading one, the highest set bit wins
    always_comb begin
        leadPos = '0;
        for (int i = 0; i < fixedWidth; i++) begin
            if (magnitude[i]) begin
                leadPos = ($clog2(fixedWidth))'(i);
            end
        end
    end

    // move the leading one up to bit fracBits, the hidden position
    assign normalized = magnitude << (fracBits - leadPos);

    // ------------------------------------------------------------------------
    // pack
    // ------------------------------------------------------------------------

    always_comb begin
        // zero input leaves +0.0
        result = '0;
        if (magnitude != '0) begin
            result.fields.sign     = isNegative;
            // value is 1.f * 2^(leadPos - fracBits)
            result.fields.exponent = 8'(floatBias - fracBits) + 8'(leadPos);
            result.fields.mantissa = {normalized[fracBits-1:0], 3'b000};
        end
    end

endmodule

// File: sim/cosineTests.svh
`ifndef COSINE_TESTS_SVH
`define COSINE_TESTS_SVH

// ----------------------------------------------------------------------------
// checking helpers
// ----------------------------------------------------------------------------

task automatic checkCount(input string name, input int expected, input int actual);
    if (expected != actual) begin
        $display("ERR %0t %s: expected %0d, actual %0d", $time, name, expected, actual);
        errorCount++;
    end
endtask

task automatic checkWord(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
        $display("ERR %0t %s: expected %h, actual %h", $time, name, expected, actual);
        errorCount++;
    end
endtask

task automatic checkCosine(input logic [31:0] angleWord);
    real expected;
    real actual;
    real diff;
    expected = $cos(decodedAngle(angleWord));
    actual = wordToReal(result);
    diff = actual - expected;
    if (diff < 0.0) begin
        diff = -diff;
    end
    if (diff > tolerance) begin
        $display("ERR %0t result: expected %0.6f, actual %0.6f (angle %h)",
                 $time, expected, actual, angleWord);
        errorCount++;
    end
endtask

task automatic finishTest(input string name, input int errorsBefore);
    if (errorCount == errorsBefore) begin
        $display("%s: pass", name);
        testsPassed++;
    end else begin
        $display("%s: fail with %0d errors", name, errorCount - errorsBefore);
        testsFailed++;
    end
endtask

// ----------------------------------------------------------------------------
// stimulus
// ----------------------------------------------------------------------------

// returns at the enabled edge that samples start
task automatic launch(input logic [31:0] angleWord);
    @(posedge clock);
    start <= 1'b1;
    angle <= angleWord;
    clockEnable <= 1'b1;
    @(posedge clock);
    start <= 1'b0;
endtask

// counts enabled edges until done, watching for changes on stalled edges
task automatic waitDone(input bit useStalls, output int enabledEdges);
    int          totalEdges;
    logic        lastEnable;
    logic        prevDone;
    logic [31:0] prevResult;
    logic [31:0] draw;
    bit          seenDone;
    enabledEdges = 0;
    totalEdges = 0;
    lastEnable = 1'b1;
    seenDone = 1'b0;
    draw = useStalls ? randomBits(1) : 32'd1;
    clockEnable <= draw[0];
    while (totalEdges < edgeLimit && !seenDone) begin
        @(negedge clock);
        if (totalEdges > 0 && !lastEnable) begin
            checkWord("done", {31'b0, prevDone}, {31'b0, done});
            checkWord("result", prevResult, result);
        end
        prevDone = done;
        prevResult = result;
        if (done) begin
            seenDone = 1'b1;
        end else begin
            @(posedge clock);
            lastEnable = clockEnable;
            totalEdges++;
            if (lastEnable) begin
                enabledEdges++;
            end
            draw = useStalls ? randomBits(1) : 32'd1;
            clockEnable <= draw[0];
        end
    end
    if (!seenDone) begin
        $display("done never rose within %0d cycles of start", edgeLimit);
        errorCount++;
    end
endtask

task automatic runAngle(input logic [31:0] angleWord, input bit useStalls);
    int edges;
    launch(angleWord);
    waitDone(useStalls, edges);
    checkCount("done latency", 16, edges);
    checkCosine(angleWord);
endtask

// ----------------------------------------------------------------------------
// tests
// ----------------------------------------------------------------------------

task automatic resetStateTest();
    int errorsBefore;
    errorsBefore = errorCount;
    repeat (20) begin
        @(negedge clock);
        checkWord("done", 32'd0, {31'b0, done});
    end
    finishTest("reset state", errorsBefore);
endtask

task automatic knownAnglesTest();
    int errorsBefore;
    errorsBefore = errorCount;
    runAngle(32'h00000000, 1'b0);
    runAngle(32'h3E800000, 1'b0);
    runAngle(32'h3F000000, 1'b0);
    runAngle(32'h3F666666, 1'b0);
    finishTest("known angles", errorsBefore);
endtask

task automatic signAndRangeTest();
    int          errorsBefore;
    logic [31:0] positiveResult;
    errorsBefore = errorCount;
    runAngle(32'h3F000000, 1'b0);
    positiveResult = result;
    runAngle(32'hBF000000, 1'b0);
    checkWord("result", positiveResult, result);
    // 2^-22 decodes to zero
    runAngle(32'h34800000, 1'b0);
    // 1.5 saturates
    runAngle(32'h3FC00000, 1'b0);
    finishTest("sign and range", errorsBefore);
endtask

task automatic backPressureTest();
    int errorsBefore;
    errorsBefore = errorCount;
    runAngle(32'h3F666666, 1'b1);
    runAngle(32'h3E800000, 1'b1);
    runAngle(32'h3F400000, 1'b1);
    finishTest("clock enable stalls", errorsBefore);
endtask

task automatic restartHoldTest();
    int          errorsBefore;
    int          edges;
    logic [31:0] heldResult;
    errorsBefore = errorCount;
    launch(32'h3F666666);
    repeat (5) @(posedge clock);
    launch(32'h3E800000);
    waitDone(1'b0, edges);
    checkCount("done latency", 16, edges);
    checkCosine(32'h3E800000);
    heldResult = result;
    repeat (10) begin
        @(negedge clock);
        checkCount("done", 1, done);
        checkWord("result", heldResult, result);
    end
    finishTest("restart and hold", errorsBefore);
endtask

task automatic randomAnglesTest();
    int          errorsBefore;
    logic [31:0] signBit;
    logic [31:0] expDrop;
    logic [31:0] mantissa;
    errorsBefore = errorCount;
    repeat (50) begin
        signBit = randomBits(1);
        expDrop = randomBits(3);
        mantissa = randomBits(23);
        // exponent 119 to 126 keeps the magnitude below one
        runAngle({signBit[0], 8'(126 - expDrop), mantissa[22:0]}, 1'b0);
    end
    finishTest("random angles", errorsBefore);
endtask

`endif

// File: sim/cosineUnitTb.sv
`timescale 1ns/1ps

module cosineUnitTb;

    localparam int clockPeriod = 20;
    localparam int edgeLimit   = 100;
    // launch plus sixteen iterations
    localparam int runCycles   = 18;
    // reset and idle check, 58 plain runs, 3 stalled runs, restart and hold
    localparam int testCycles  = 24 + 58 * runCycles + 3 * (2 + edgeLimit) + 35;
    localparam int marginCycles = 400;
    localparam real tolerance  = 1.0 / 16384.0;
    localparam logic [15:0] lfsrSeed = 16'd9795;

    logic        clock = 1'b0;
    logic        reset;
    logic        clockEnable;
    logic        start;
    logic [31:0] angle;
    logic [31:0] result;
    logic        done;

    logic [15:0] lfsrState = lfsrSeed;
    int          errorCount = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;

    always #(clockPeriod / 2) clock = ~clock;

    cosineUnit dut (
        .clock       (clock),
        .reset       (reset),
        .clockEnable (clockEnable),
        .start       (start),
        .angle       (angle),
        .result      (result),
        .done        (done)
    );

    // ------------------------------------------------------------------------
    // random source
    // ------------------------------------------------------------------------

    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return bits;
    endfunction

    // ------------------------------------------------------------------------
    // float reference model
    // ------------------------------------------------------------------------

    function automatic real floatMagnitude(input logic [31:0] word);
        int  exponent;
        real mantissa;
        exponent = word[30:23];
        if (exponent == 0) begin
            return 0.0;
        end
        mantissa = 1.0 + $itor(word[22:0]) / 8388608.0;
        return mantissa * (2.0 ** (exponent - 127));
    endfunction

    function automatic real wordToReal(input logic [31:0] word);
        return word[31] ? -floatMagnitude(word) : floatMagnitude(word);
    endfunction

    // magnitude truncated to Q1.20, clamped just below one radian
    function automatic real decodedAngle(input logic [31:0] word);
        real magnitude;
        real scale;
        scale = 1048576.0;
        magnitude = floatMagnitude(word);
        if (magnitude >= 1.0) begin
            return (scale - 1.0) / scale;
        end
        return $floor(magnitude * scale) / scale;
    endfunction

    `include "cosineTests.svh"

    initial begin
        reset <= 1'b1;
        clockEnable <= 1'b0;
        start <= 1'b0;
        angle <= '0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        resetStateTest();
        knownAnglesTest();
        signAndRangeTest();
        backPressureTest();
        restartHoldTest();
        randomAnglesTest();

        $display("tests passed %0d, failed %0d, errors %0d",
                 testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((testCycles + marginCycles) * clockPeriod);
        $display("timeout: simulation ran past its cycle budget");
        $display("*** FAILED ***");
        $finish;
    end

endmodule
